// File: common/rv_decode_defs.svh
`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

`define RVD_NUM_LANES    4
`define RVD_INST_DEPTH   8
`define RVD_RES_DEPTH    8

`define RVD_APB_AW       8
`define RVD_ADDR_INST    8'h00
`define RVD_ADDR_STATUS  8'h04
`define RVD_ADDR_RES_DEC 8'h08
`define RVD_ADDR_RES_IMM 8'h0C
`define RVD_ADDR_BUBBLE  8'h10

`define RVD_DEC_W        28
`define RVD_QCNT_W       ($clog2(`RVD_INST_DEPTH + 1))
`define RVD_RCNT_W       ($clog2(`RVD_RES_DEPTH + 1))

`endif

// File: common/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

  // RV32I major opcodes handled by the decode lanes
  typedef enum logic [6:0] {
    OPC_BUBBLE = 7'b0000000,  // All-zero filler word
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // Immediate layout selected by the opcode
  typedef enum logic [2:0] {
    FMT_NONE = 3'd0,  // OP, bubble and unknown opcodes
    FMT_I    = 3'd1,
    FMT_S    = 3'd2,
    FMT_B    = 3'd3,
    FMT_J    = 3'd4
  } imm_fmt_e;

endpackage

`default_nettype wire

// File: hdl/apb_slave.sv
`default_nettype none
`include "rv_decode_defs.svh"

module apb_slave (
  input  wire                     CLK,
  input  wire                     reset,
  input  wire                     PSEL,
  input  wire                     PENABLE,
  input  wire                     PWRITE,
  input  wire  [`RVD_APB_AW-1:0]  PADDR,
  input  wire  [31:0]             PWDATA,
  output logic [31:0]             PRDATA,
  output logic                    PREADY,
  output logic                    PSLVERR,
  output logic                    push,
  output logic [31:0]             push_inst,
  input  wire                     queue_full,
  input  wire  [`RVD_QCNT_W-1:0]  queue_count,
  input  wire  [`RVD_DEC_W-1:0]   res_dec,
  input  wire  [31:0]             res_imm,
  input  wire  [`RVD_RCNT_W-1:0]  res_count,
  output logic                    pop
);
  import rv_decode_pkg::*;

  logic     access;
  logic     wr_acc;
  logic     rd_acc;
  logic     hit_inst;
  logic     hit_bubble;
  logic     hit_status;
  logic     hit_dec;
  logic     hit_imm;
  logic     res_empty;
  imm_fmt_e head_fmt;

  assign access = PSEL && PENABLE;  // Access phase only
  assign wr_acc = access && PWRITE;
  assign rd_acc = access && !PWRITE;

  assign hit_inst   = (PADDR == `RVD_ADDR_INST);
  assign hit_bubble = (PADDR == `RVD_ADDR_BUBBLE);
  assign hit_status = (PADDR == `RVD_ADDR_STATUS);
  assign hit_dec    = (PADDR == `RVD_ADDR_RES_DEC);
  assign hit_imm    = (PADDR == `RVD_ADDR_RES_IMM);

  assign res_empty = (res_count == '0);
  assign head_fmt  = imm_fmt_e'(res_dec[27:25]);

  assign push      = wr_acc && (hit_inst || hit_bubble) && !queue_full;
  assign push_inst = hit_bubble ? 32'h0 : PWDATA;  // Bubble data ignored
  assign pop       = rd_acc && hit_imm && !res_empty;

  assign PREADY = 1'b1;  // No wait states

  always_comb begin
    PRDATA  = '0;
    PSLVERR = 1'b0;
    if (wr_acc) begin
      if (hit_inst || hit_bubble) begin
        PSLVERR = queue_full;
      end else begin
        PSLVERR = 1'b1;  // Not a writable address
      end
    end else if (rd_acc) begin
      if (hit_status) begin
        PRDATA = {16'h0, 8'(res_count), 8'(queue_count)};
      end else if (hit_dec || hit_imm) begin
        if (res_empty) begin
          PSLVERR = 1'b1;
        end else if (hit_dec) begin
          PRDATA = {4'h0, head_fmt, res_dec[24:0]};
        end else begin
          PRDATA = res_imm;
        end
      end else begin
        PSLVERR = 1'b1;  // Not a readable address
      end
    end
  end

  a_setup_then_access: assert property (
    @(posedge CLK) disable iff (reset)
    PSEL && !PENABLE |=> PSEL && PENABLE && $stable(PADDR) && $stable(PWRITE)
  ) else $error("APB setup phase not followed by a matching access phase");

endmodule

`default_nettype wire

// File: decode/decode_dispatch.sv
`default_nettype none
`include "rv_decode_defs.svh"

module decode_dispatch (
  input  wire                                CLK,
  input  wire                                reset,
  input  wire                                push,
  input  wire  [31:0]                        push_inst,
  output logic                               queue_full,
  output logic [`RVD_QCNT_W-1:0]             queue_count,
  output logic [`RVD_NUM_LANES-1:0]          lane_valid,
  output logic [`RVD_NUM_LANES-1:0][31:0]    lane_inst,
  input  wire  [`RVD_NUM_LANES-1:0]          lane_ready
);

  localparam int DEPTH = `RVD_INST_DEPTH;
  localparam int LANES = `RVD_NUM_LANES;
  localparam int QCW   = `RVD_QCNT_W;
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int LW    = (LANES > 1) ? $clog2(LANES) : 1;

  logic [31:0]   inst_mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [LW-1:0] iss_ptr;  // Round-robin lane pointer
  logic          not_empty;
  logic          issue;

  assign not_empty  = (queue_count != '0);
  assign queue_full = (queue_count == QCW'(DEPTH));
  assign issue      = not_empty && lane_ready[iss_ptr];

  // Head word is broadcast, only the pointed lane sees valid
  assign lane_inst = {LANES{inst_mem[rd_ptr]}};

  always_comb begin
    lane_valid          = '0;
    lane_valid[iss_ptr] = not_empty;
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      inst_mem[wr_ptr] <= push_inst;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      iss_ptr     <= '0;
      queue_count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (issue) begin
        rd_ptr  <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        iss_ptr <= (iss_ptr == LW'(LANES - 1)) ? '0 : iss_ptr + 1'b1;
      end
      case ({push, issue})
        2'b10:   queue_count <= queue_count + 1'b1;
        2'b01:   queue_count <= queue_count - 1'b1;
        default: ;
      endcase
    end
  end

  a_no_push_when_full: assert property (
    @(posedge CLK) disable iff (reset) push |-> !queue_full
  ) else $error("push into a full instruction queue");

endmodule

`default_nettype wire

// File: decode/decode_lane.sv
`default_nettype none
`include "rv_decode_defs.svh"

module decode_lane (
  input  wire                    CLK,
  input  wire                    reset,
  input  wire                    in_valid,
  output logic                   in_ready,
  input  wire  [31:0]            in_inst,
  output logic                   out_valid,
  input  wire                    out_ready,
  output logic [`RVD_DEC_W-1:0]  dec_word,
  output logic [31:0]            imm
);
  import rv_decode_pkg::*;

  logic        s1_valid;
  logic [31:0] s1_inst;  // Instruction register
  logic        s2_load;
  opcode_e     opc;
  imm_fmt_e    fmt_d;
  logic [31:0] imm_d;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  funct3;
  logic [6:0]  funct7;

  // Stage 2 takes a new item when empty or draining this cycle
  assign s2_load  = s1_valid && (!out_valid || out_ready);
  assign in_ready = !s1_valid || s2_load;

  assign rd     = s1_inst[11:7];
  assign rs1    = s1_inst[19:15];
  assign rs2    = s1_inst[24:20];
  assign funct3 = s1_inst[14:12];
  assign funct7 = s1_inst[31:25];

  always_comb begin
    opc   = opcode_e'(s1_inst[6:0]);
    imm_d = '0;
    fmt_d = FMT_NONE;
    case (opc)
      OPC_LOAD, OPC_JALR, OPC_OP_IMM: begin
        imm_d = {{20{s1_inst[31]}}, s1_inst[31:20]};
        fmt_d = FMT_I;
      end
      OPC_STORE: begin
        imm_d = {{20{s1_inst[31]}}, s1_inst[31:25], s1_inst[11:7]};
        fmt_d = FMT_S;
      end
      OPC_BRANCH: begin
        imm_d = {{19{s1_inst[31]}}, s1_inst[31], s1_inst[7],
                 s1_inst[30:25], s1_inst[11:8], 1'b0};
        fmt_d = FMT_B;
      end
      OPC_JAL: begin
        imm_d = {{11{s1_inst[31]}}, s1_inst[31], s1_inst[19:12],
                 s1_inst[20], s1_inst[30:21], 1'b0};
        fmt_d = FMT_J;
      end
      OPC_OP, OPC_BUBBLE: ;  // No immediate
      default: ;  // Unknown opcode, fields still split
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s1_inst  <= '0;
    end else if (in_valid && in_ready) begin
      s1_valid <= 1'b1;
      s1_inst  <= in_inst;
    end else if (s2_load) begin
      s1_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      out_valid <= 1'b0;
      dec_word  <= '0;
      imm       <= '0;
    end else if (s2_load) begin
      out_valid <= 1'b1;
      dec_word  <= {fmt_d, funct7, funct3, rs2, rs1, rd};
      imm       <= imm_d;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  a_out_hold: assert property (
    @(posedge CLK) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(dec_word) && $stable(imm)
  ) else $error("lane output changed before it was taken");

endmodule

`default_nettype wire

// File: decode/decode_collect.sv
`default_nettype none
`include "rv_decode_defs.svh"

module decode_collect (
  input  wire                                        CLK,
  input  wire                                        reset,
  input  wire  [`RVD_NUM_LANES-1:0]                  lane_valid,
  output logic [`RVD_NUM_LANES-1:0]                  lane_ready,
  input  wire  [`RVD_NUM_LANES-1:0][`RVD_DEC_W-1:0]  lane_dec,
  input  wire  [`RVD_NUM_LANES-1:0][31:0]            lane_imm,
  input  wire                                        pop,
  output logic [`RVD_DEC_W-1:0]                      res_dec,
  output logic [31:0]                                res_imm,
  output logic [`RVD_RCNT_W-1:0]                     res_count
);
  import rv_decode_pkg::*;

  localparam int DEPTH = `RVD_RES_DEPTH;
  localparam int LANES = `RVD_NUM_LANES;
  localparam int DW    = `RVD_DEC_W;
  localparam int RCW   = `RVD_RCNT_W;
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int LW    = (LANES > 1) ? $clog2(LANES) : 1;

  logic [DW-1:0] dec_mem [DEPTH];
  logic [31:0]   imm_mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [LW-1:0] drain_ptr;  // Follows dispatch order
  logic          room;
  logic          accept;
  logic [DW-1:0] sel_dec;
  logic [31:0]   sel_imm;
  imm_fmt_e      sel_fmt;

  assign sel_dec = lane_dec[drain_ptr];
  assign sel_imm = lane_imm[drain_ptr];
  assign sel_fmt = imm_fmt_e'(sel_dec[DW-1 -: 3]);
  assign room    = (res_count != RCW'(DEPTH));
  assign accept  = room && lane_valid[drain_ptr];

  always_comb begin
    lane_ready            = '0;
    lane_ready[drain_ptr] = room;
  end

  assign res_dec = dec_mem[rd_ptr];
  assign res_imm = imm_mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (accept) begin
      dec_mem[wr_ptr] <= sel_dec;
      imm_mem[wr_ptr] <= sel_imm;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      drain_ptr <= '0;
      res_count <= '0;
    end else begin
      if (accept) begin
        wr_ptr    <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        drain_ptr <= (drain_ptr == LW'(LANES - 1)) ? '0 : drain_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({accept, pop})
        2'b10:   res_count <= res_count + 1'b1;
        2'b01:   res_count <= res_count - 1'b1;
        default: ;
      endcase
    end
  end

  a_no_pop_when_empty: assert property (
    @(posedge CLK) disable iff (reset) pop |-> res_count != '0
  ) else $error("pop from an empty result FIFO");

  // Lane decode must never pair format NONE with a live immediate
  a_none_has_zero_imm: assert property (
    @(posedge CLK) disable iff (reset) accept && sel_fmt == FMT_NONE |-> sel_imm == '0
  ) else $error("format NONE with nonzero immediate");

endmodule

`default_nettype wire

// File: hdl/rv_decode_top.sv
`default_nettype none
`include "rv_decode_defs.svh"

module rv_decode_top (
  input  wire                     CLK,
  input  wire                     reset,
  input  wire                     PSEL,
  input  wire                     PENABLE,
  input  wire                     PWRITE,
  input  wire  [`RVD_APB_AW-1:0]  PADDR,
  input  wire  [31:0]             PWDATA,
  output wire  [31:0]             PRDATA,
  output wire                     PREADY,
  output wire                     PSLVERR
);

  localparam int LANES = `RVD_NUM_LANES;

  wire                               push;
  wire [31:0]                        push_inst;
  wire                               queue_full;
  wire [`RVD_QCNT_W-1:0]             queue_count;
  wire                               pop;
  wire [`RVD_DEC_W-1:0]              res_dec;
  wire [31:0]                        res_imm;
  wire [`RVD_RCNT_W-1:0]             res_count;
  wire [LANES-1:0]                   in_valid;
  wire [LANES-1:0]                   in_ready;
  wire [LANES-1:0][31:0]             in_inst;
  wire [LANES-1:0]                   out_valid;
  wire [LANES-1:0]                   out_ready;
  wire [LANES-1:0][`RVD_DEC_W-1:0]   out_dec;
  wire [LANES-1:0][31:0]             out_imm;

  apb_slave u_apb (
    .CLK, .reset, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
    .PRDATA, .PREADY, .PSLVERR,
    .push, .push_inst, .queue_full, .queue_count,
    .res_dec, .res_imm, .res_count, .pop
  );

  decode_dispatch u_dispatch (
    .CLK, .reset, .push, .push_inst, .queue_full, .queue_count,
    .lane_valid(in_valid), .lane_inst(in_inst), .lane_ready(in_ready)
  );

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    decode_lane u_lane (
      .CLK, .reset,
      .in_valid(in_valid[i]), .in_ready(in_ready[i]), .in_inst(in_inst[i]),
      .out_valid(out_valid[i]), .out_ready(out_ready[i]),
      .dec_word(out_dec[i]), .imm(out_imm[i])
    );
  end

  decode_collect u_collect (
    .CLK, .reset,
    .lane_valid(out_valid), .lane_ready(out_ready),
    .lane_dec(out_dec), .lane_imm(out_imm),
    .pop, .res_dec, .res_imm, .res_count
  );

endmodule

`default_nettype wire

// File: verif/tb_clkgen.sv
`default_nettype none

module tb_clkgen (
  output logic CLK,
  output logic reset
);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;  // Period 20
  end

  initial begin
    reset = 1'b1;
    repeat (3) @(posedge CLK);
    #2;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: verif/tb_rv_decode.sv
`default_nettype none
`include "rv_decode_defs.svh"

module tb_rv_decode;
  import rv_decode_pkg::*;

  logic        CLK;
  logic        reset;
  logic        PSEL;
  logic        PENABLE;
  logic        PWRITE;
  logic [7:0]  PADDR;
  logic [31:0] PWDATA;
  wire  [31:0] PRDATA;
  wire         PREADY;
  wire         PSLVERR;

  logic [63:0] exp_q [$];  // Expected {dec word, imm} in input order
  logic [15:0] lfsr_state = 16'd64390;
  logic [6:0]  opcs [8] = '{OPC_STORE, OPC_JAL, OPC_LOAD, OPC_JALR,
                            OPC_OP_IMM, OPC_BRANCH, OPC_OP, OPC_BUBBLE};
  int          to_check = 0;
  int          errors = 0;
  int          tests_failed = 0;

  tb_clkgen clkgen (.CLK, .reset);

  rv_decode_top dut0 (
    .CLK, .reset, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
    .PRDATA, .PREADY, .PSLVERR
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $finish;
  endtask

  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (out ? 16'hB400 : 16'h0);
    return out;
  endfunction

  function automatic logic [31:0] lfsr_word(input int nbits);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < nbits; i++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  // Expected RES_DEC word and immediate, straight from the RV32I formats
  function automatic logic [63:0] decode_ref(input logic [31:0] inst);
    logic [31:0] imm;
    imm_fmt_e    fmt;
    imm = '0;
    fmt = FMT_NONE;
    case (inst[6:0])
      OPC_LOAD, OPC_JALR, OPC_OP_IMM: begin
        fmt = FMT_I;
        imm = $signed(inst) >>> 20;
      end
      OPC_STORE: begin
        fmt = FMT_S;
        imm = $signed({inst[31:25], inst[11:7], 20'h0}) >>> 20;
      end
      OPC_BRANCH: begin
        fmt = FMT_B;
        imm = $signed({inst[31], inst[7], inst[30:25], inst[11:8], 20'h0}) >>> 19;
      end
      OPC_JAL: begin
        fmt = FMT_J;
        imm = $signed({inst[31], inst[19:12], inst[20], inst[30:21], 12'h0}) >>> 11;
      end
      default: ;  // OP, bubble and unknown stay zero
    endcase
    return {4'h0, fmt, inst[31:25], inst[14:12], inst[24:20], inst[19:15], inst[11:7], imm};
  endfunction

  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge CLK);
    #2;
    PSEL   = 1'b1;  // Setup phase
    PWRITE = wr;
    PADDR  = addr;
    PWDATA = wdata;
    @(posedge CLK);
    #2;
    PENABLE = 1'b1;
    #8;
    rdata = PRDATA;  // Mid access phase
    err   = PSLVERR;
    @(posedge CLK);
    #2;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s exp 0x%08h got 0x%08h", name, exp, got);
      errors++;
    end
  endtask

  task automatic send_inst(input logic [7:0] addr, input logic [31:0] word);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, addr, word, rdata, err);
    compare_value("PSLVERR", err, 32'h0);
    exp_q.push_back(decode_ref(addr == `RVD_ADDR_BUBBLE ? 32'h0 : word));
  endtask

  task automatic drain(input int n);
    int t;
    t = 0;
    to_check = n;
    while (to_check != 0 && t < 2000) begin
      @(posedge CLK);
      t++;
    end
    if (to_check != 0) begin
      abort_run("Timed out while draining the result FIFO");
    end
  endtask

  task automatic report(input string name, input int mark);
    $display("%s: %s", name, (errors == mark) ? "pass" : "fail");
    if (errors != mark) begin
      tests_failed++;
    end
  endtask

  // Pops results over APB while the stimulus process waits in drain
  initial begin : compare_results
    logic [31:0] rdata;
    logic [31:0] imm;
    logic        err;
    logic [63:0] exp;
    int          polls;
    forever begin
      @(posedge CLK);
      if (to_check > 0) begin
        polls = 0;
        rdata = '0;
        while (rdata[15:8] == 8'h0 && polls < 40) begin
          apb_xfer(1'b0, `RVD_ADDR_STATUS, '0, rdata, err);
          polls++;
        end
        if (rdata[15:8] == 8'h0 || exp_q.size() == 0) begin
          abort_run("No result showed up, or a result came with nothing expected");
        end else begin
          exp = exp_q.pop_front();
          apb_xfer(1'b0, `RVD_ADDR_RES_DEC, '0, rdata, err);
          compare_value("RES_DEC", rdata, exp[63:32]);
          apb_xfer(1'b0, `RVD_ADDR_RES_IMM, '0, imm, err);
          compare_value("RES_IMM", imm, exp[31:0]);
          compare_value("PSLVERR", err, 32'h0);
          to_check--;
        end
      end
    end
  end

  initial begin : stimulus
    logic [31:0] rdata;
    logic [31:0] word;
    logic        err;
    int          mark;
    int          t;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = '0;
    PWDATA  = '0;
    t = 0;
    while (reset !== 1'b0 && t < 20) begin
      @(posedge CLK);
      t++;
    end
    if (reset !== 1'b0) begin
      abort_run("Reset never released");
    end

    mark = errors;
    compare_value("PREADY", PREADY, 32'h1);
    apb_xfer(1'b0, `RVD_ADDR_STATUS, '0, rdata, err);
    compare_value("STATUS", rdata, 32'h0);
    apb_xfer(1'b0, `RVD_ADDR_RES_IMM, '0, rdata, err);
    compare_value("PSLVERR", err, 32'h1);  // Empty FIFO
    apb_xfer(1'b0, 8'h20, '0, rdata, err);
    compare_value("PSLVERR", err, 32'h1);  // Unmapped
    report("test 1 after reset", mark);

    mark = errors;
    for (int i = 0; i < 7; i++) begin
      send_inst(`RVD_ADDR_INST, 32'h3A5C_4E80 | opcs[i]);  // Sign bit clear
      send_inst(`RVD_ADDR_INST, 32'hC5A3_B100 | opcs[i]);  // Sign bit set
    end
    drain(14);
    report("test 2 formats", mark);

    mark = errors;
    send_inst(`RVD_ADDR_BUBBLE, 32'hFFFF_FFFF);
    send_inst(`RVD_ADDR_INST, 32'hFEDC_B0B7);  // LUI, not decoded here
    drain(2);
    report("test 3 bubble and unknown", mark);

    mark = errors;
    for (int b = 0; b < 4; b++) begin
      for (int i = 0; i < 10; i++) begin
        word[6:0]  = opcs[lfsr_word(3)];
        word[31:7] = lfsr_word(25);
        send_inst(`RVD_ADDR_INST, word);
      end
      drain(10);
    end
    report("test 4 random stream", mark);

    mark = errors;
    for (int i = 0; i < 24; i++) begin
      send_inst(`RVD_ADDR_INST, lfsr_word(32));
    end
    apb_xfer(1'b1, `RVD_ADDR_INST, 32'h0000_0013, rdata, err);
    compare_value("PSLVERR", err, 32'h1);  // Queue and pipeline full
    drain(24);
    apb_xfer(1'b0, `RVD_ADDR_STATUS, '0, rdata, err);
    compare_value("STATUS", rdata, 32'h0);
    report("test 5 back-pressure", mark);

    $display("5 tests, %0d failed, %0d check errors", tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_decode_top.f
+incdir+common
common/rv_decode_pkg.sv
hdl/apb_slave.sv
decode/decode_dispatch.sv
decode/decode_lane.sv
decode/decode_collect.sv
hdl/rv_decode_top.sv
verif/tb_clkgen.sv
verif/tb_rv_decode.sv
